//--- rtl/periph_bus_pkg.sv
// Peripheral bus constants
`default_nettype none

package periph_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Wishbone widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned BusAddrWidth  = 32;
  localparam int unsigned BusDataWidth  = 32;
  localparam int unsigned BusByteEnable = 4;

  // Register index inside a device is a word offset
  localparam int unsigned RegAddrWidth = 8;
  localparam int unsigned RegAddrLsb   = 2;   // Byte address bits 1:0 dropped

  //////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned DevSelLsb   = 10;  // Select field at bits 11:10
  localparam int unsigned DevSelWidth = 2;

  // Select value 3 is unmapped, as is any set bit above the field
  localparam logic [DevSelWidth-1:0] DevGpio  = 2'd0;
  localparam logic [DevSelWidth-1:0] DevPwm   = 2'd1;
  localparam logic [DevSelWidth-1:0] DevTimer = 2'd2;

endpackage

`default_nettype wire

//--- rtl/periph_reg_pkg.sv
// Device register definitions
`default_nettype none

package periph_reg_pkg;

  // Device widths
  localparam int unsigned GpiWidth   = 13;
  localparam int unsigned GpoWidth   = 24;
  localparam int unsigned PwmWidth   = 12;
  localparam int unsigned PwmCtrSize = 8;
  localparam int unsigned MtimeWidth = 64;

  // GPIO offsets
  localparam int unsigned GpioOutReg = 0;
  localparam int unsigned GpioInReg  = 1;

  // Timer offsets, low half first
  localparam int unsigned TimerMtimeLoReg = 0;
  localparam int unsigned TimerMtimeHiReg = 1;
  localparam int unsigned TimerCmpLoReg   = 2;
  localparam int unsigned TimerCmpHiReg   = 3;

  // PWM channel word, seen by the bus as raw and by the counter as fields
  typedef union packed {
    logic [periph_bus_pkg::BusDataWidth-1:0] raw;
    struct packed {
      logic [periph_bus_pkg::BusDataWidth-2*PwmCtrSize-1:0] rsvd;
      logic [PwmCtrSize-1:0]                                period;
      logic [PwmCtrSize-1:0]                                duty;   // Low byte
    } f;
  } pwm_cfg_u;

  // Byte-lane write of new_word over old_word
  function automatic logic [periph_bus_pkg::BusDataWidth-1:0] merge_bytes(
    input logic [periph_bus_pkg::BusDataWidth-1:0]  old_word,
    input logic [periph_bus_pkg::BusDataWidth-1:0]  new_word,
    input logic [periph_bus_pkg::BusByteEnable-1:0] sel
  );
    logic [periph_bus_pkg::BusDataWidth-1:0] merged;
    merged = old_word;
    for (int b = 0; b < periph_bus_pkg::BusByteEnable; b++) begin
      if (sel[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- rtl/wb_device_decode.sv
// Wishbone device decoder
`default_nettype none
`timescale 1ns/10ps

module wb_device_decode
  import periph_bus_pkg::*;
(
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,

  // Wishbone classic target
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [BusAddrWidth-1:0]  wb_adr_i,
  input  logic [BusByteEnable-1:0] wb_sel_i,
  input  logic [BusDataWidth-1:0]  wb_dat_i,
  output logic [BusDataWidth-1:0]  wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     wb_err_o,

  // Shared device request
  input  logic [BusDataWidth-1:0]  gpio_rdata_i,
  input  logic [BusDataWidth-1:0]  pwm_rdata_i,
  input  logic [BusDataWidth-1:0]  tmr_rdata_i,
  output logic                     gpio_req_o,
  output logic                     pwm_req_o,
  output logic                     tmr_req_o,
  output logic                     dev_we_o,
  output logic [RegAddrWidth-1:0]  dev_addr_o,
  output logic [BusDataWidth-1:0]  dev_wdata_o,
  output logic [BusByteEnable-1:0] dev_sel_o
);

  logic [DevSelWidth-1:0]  dev_sel;
  logic                    addr_high;
  logic                    unmapped;
  logic                    rsp_pending;
  logic                    accept;
  logic [BusDataWidth-1:0] rdata_mux;

  assign dev_sel   = wb_adr_i[DevSelLsb +: DevSelWidth];
  assign addr_high = |wb_adr_i[BusAddrWidth-1:DevSelLsb+DevSelWidth];
  assign unmapped  = addr_high | !(dev_sel inside {DevGpio, DevPwm, DevTimer});

  // A response in flight blocks a second accept of the same request
  assign rsp_pending = wb_ack_o | wb_err_o;
  assign accept      = wb_cyc_i & wb_stb_i & ~rsp_pending;

  assign gpio_req_o = accept & ~unmapped & (dev_sel == DevGpio);
  assign pwm_req_o  = accept & ~unmapped & (dev_sel == DevPwm);
  assign tmr_req_o  = accept & ~unmapped & (dev_sel == DevTimer);

  assign dev_we_o    = wb_we_i;
  assign dev_addr_o  = wb_adr_i[RegAddrLsb +: RegAddrWidth];
  assign dev_wdata_o = wb_dat_i;
  assign dev_sel_o   = wb_sel_i;

  always_comb begin
    rdata_mux = '0;
    if (!unmapped) begin
      case (dev_sel)
        DevGpio:  rdata_mux = gpio_rdata_i;
        DevPwm:   rdata_mux = pwm_rdata_i;
        DevTimer: rdata_mux = tmr_rdata_i;
        default:  rdata_mux = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= accept & ~unmapped;
      wb_err_o <= accept & unmapped;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (accept) wb_dat_o <= rdata_mux; // Same edge as ack
  end

  // Only one kind of response per access
  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !(wb_ack_o && wb_err_o))
    else $error("ack and err high together");

  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    rsp_pending |=> !rsp_pending)
    else $error("bus response held for two cycles");

endmodule

`default_nettype wire

//--- rtl/gpio_block.sv
// GPIO register block
`default_nettype none
`timescale 1ns/10ps

module gpio_block
  import periph_bus_pkg::*;
  import periph_reg_pkg::*;
(
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,

  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [RegAddrWidth-1:0]  reg_addr_i,
  input  logic [BusDataWidth-1:0]  wdata_i,
  input  logic [BusByteEnable-1:0] sel_i,
  output logic [BusDataWidth-1:0]  rdata_o,

  input  logic [GpiWidth-1:0]      gp_i,
  output logic [GpoWidth-1:0]      gp_o
);

  logic [GpoWidth-1:0]     gpo_q;
  logic [BusDataWidth-1:0] gpo_merged;
  logic                    gpo_wr;
  logic [GpiWidth-1:0]     gpi_meta_q;
  logic [GpiWidth-1:0]     gpi_sync_q;

  // Output register

  assign gpo_wr     = req_i & we_i & (reg_addr_i == RegAddrWidth'(GpioOutReg));
  assign gpo_merged = merge_bytes(BusDataWidth'(gpo_q), wdata_i, sel_i);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q <= '0;
    end else if (gpo_wr) begin
      gpo_q <= gpo_merged[GpoWidth-1:0]; // Upper lanes dropped
    end
  end

  assign gp_o = gpo_q;

  // Input synchronizer, two flops
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  // Read data, zero-extended
  always_comb begin
    rdata_o = '0;
    if (req_i) begin
      case (reg_addr_i)
        RegAddrWidth'(GpioOutReg): rdata_o = BusDataWidth'(gpo_q);
        RegAddrWidth'(GpioInReg):  rdata_o = BusDataWidth'(gpi_sync_q);
        default:                   rdata_o = '0;   // Unused offset
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/pwm_block.sv
// PWM channel block
`default_nettype none
`timescale 1ns/10ps

module pwm_block
  import periph_bus_pkg::*;
  import periph_reg_pkg::*;
(
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,

  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [RegAddrWidth-1:0]  reg_addr_i,
  input  logic [BusDataWidth-1:0]  wdata_i,
  input  logic [BusByteEnable-1:0] sel_i,
  output logic [BusDataWidth-1:0]  rdata_o,

  output logic [PwmWidth-1:0]      pwm_o
);

  pwm_cfg_u            cfg_q [PwmWidth];  // One word per channel
  logic [PwmWidth-1:0] chan_wr;

  //////////////////////////////////////////////////////////////////////
  // Channels
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < PwmWidth; i++) begin : gen_chan
    logic [PwmCtrSize-1:0] ctr_q;
    logic [PwmCtrSize-1:0] duty_q;     // Active duty
    logic [PwmCtrSize-1:0] period_q;   // Active period
    logic                  wrap;

    assign chan_wr[i] = req_i & we_i & (reg_addr_i == RegAddrWidth'(i));

    always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
      if (!rst_sys_ni) begin
        cfg_q[i] <= '0;
      end else if (chan_wr[i]) begin
        cfg_q[i].raw <= merge_bytes(cfg_q[i].raw, wdata_i, sel_i);
      end
    end

    // Period zero wraps every cycle, so the counter sits at zero
    assign wrap = (ctr_q == period_q);

    always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
      if (!rst_sys_ni) begin
        ctr_q    <= '0;
        duty_q   <= '0;
        period_q <= '0;
      end else if (wrap) begin
        ctr_q    <= '0;
        duty_q   <= cfg_q[i].f.duty;    // New config only at wrap
        period_q <= cfg_q[i].f.period;
      end else begin
        ctr_q <= ctr_q + 1'b1;
      end
    end

    assign pwm_o[i] = (period_q != '0) & (ctr_q < duty_q);

    // Counter stays within the period loaded at the last wrap
    assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
      ctr_q <= period_q)
      else $error("PWM channel %0d counter past its period", i);
  end : gen_chan

  //////////////////////////////////////////////////////////////////////
  // Read back
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    if (req_i) begin
      for (int c = 0; c < PwmWidth; c++) begin
        if (reg_addr_i == RegAddrWidth'(c)) rdata_o = cfg_q[c].raw;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/mtimer_block.sv
// Machine timer
`default_nettype none
`timescale 1ns/10ps

module mtimer_block
  import periph_bus_pkg::*;
  import periph_reg_pkg::*;
(
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,

  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [RegAddrWidth-1:0]  reg_addr_i,
  input  logic [BusDataWidth-1:0]  wdata_i,
  input  logic [BusByteEnable-1:0] sel_i,
  output logic [BusDataWidth-1:0]  rdata_o,

  output logic                     timer_irq_o
);

  logic [MtimeWidth-1:0]   mtime_q;
  logic [MtimeWidth-1:0]   mtimecmp_q;
  logic                    irq_q;
  logic                    wr_en;
  logic                    mtime_lo_wr;
  logic                    mtime_hi_wr;
  logic                    cmp_lo_wr;
  logic                    cmp_hi_wr;
  logic [BusDataWidth-1:0] mtime_lo;
  logic [BusDataWidth-1:0] mtime_hi;
  logic [BusDataWidth-1:0] cmp_lo;
  logic [BusDataWidth-1:0] cmp_hi;

  assign mtime_lo = mtime_q[BusDataWidth-1:0];
  assign mtime_hi = mtime_q[MtimeWidth-1:BusDataWidth];
  assign cmp_lo   = mtimecmp_q[BusDataWidth-1:0];
  assign cmp_hi   = mtimecmp_q[MtimeWidth-1:BusDataWidth];

  assign wr_en       = req_i & we_i;
  assign mtime_lo_wr = wr_en & (reg_addr_i == RegAddrWidth'(TimerMtimeLoReg));
  assign mtime_hi_wr = wr_en & (reg_addr_i == RegAddrWidth'(TimerMtimeHiReg));
  assign cmp_lo_wr   = wr_en & (reg_addr_i == RegAddrWidth'(TimerCmpLoReg));
  assign cmp_hi_wr   = wr_en & (reg_addr_i == RegAddrWidth'(TimerCmpHiReg));

  //////////////////////////////////////////////////////////////////////
  // Counter and compare
  //////////////////////////////////////////////////////////////////////

  // A half write replaces that cycle's increment
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q <= '0;
    end else if (mtime_lo_wr) begin
      mtime_q <= {mtime_hi, merge_bytes(mtime_lo, wdata_i, sel_i)};
    end else if (mtime_hi_wr) begin
      mtime_q <= {merge_bytes(mtime_hi, wdata_i, sel_i), mtime_lo};
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtimecmp_q <= '1;                  // Keeps the interrupt off
    end else if (cmp_lo_wr) begin
      mtimecmp_q <= {cmp_hi, merge_bytes(cmp_lo, wdata_i, sel_i)};
    end else if (cmp_hi_wr) begin
      mtimecmp_q <= {merge_bytes(cmp_hi, wdata_i, sel_i), cmp_lo};
    end
  end

  // Level interrupt, one cycle behind the compare
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign timer_irq_o = irq_q;

  always_comb begin
    rdata_o = '0;
    if (req_i) begin
      case (reg_addr_i)
        RegAddrWidth'(TimerMtimeLoReg): rdata_o = mtime_lo;
        RegAddrWidth'(TimerMtimeHiReg): rdata_o = mtime_hi;
        RegAddrWidth'(TimerCmpLoReg):   rdata_o = cmp_lo;
        RegAddrWidth'(TimerCmpHiReg):   rdata_o = cmp_hi;
        default:                        rdata_o = '0;
      endcase
    end
  end

  // Reset values of mtime and mtimecmp keep the first cycle quiet
  assert property (@(posedge clk_sys_i) $rose(rst_sys_ni) |=> !timer_irq_o)
    else $error("timer interrupt right after reset");

endmodule

`default_nettype wire

//--- rtl/periph_subsys.sv
// Peripheral subsystem top
`default_nettype none
`timescale 1ns/10ps

module periph_subsys
  import periph_bus_pkg::*;
  import periph_reg_pkg::*;
(
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,

  // Wishbone target
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [BusAddrWidth-1:0]  wb_adr_i,
  input  logic [BusByteEnable-1:0] wb_sel_i,
  input  logic [BusDataWidth-1:0]  wb_dat_i,
  output logic [BusDataWidth-1:0]  wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     wb_err_o,

  input  logic [GpiWidth-1:0]      gp_i,
  output logic [GpoWidth-1:0]      gp_o,
  output logic [PwmWidth-1:0]      pwm_o,
  output logic                     timer_irq_o
);

  // Device side of the decoder
  logic                     gpio_req;
  logic                     pwm_req;
  logic                     tmr_req;
  logic                     dev_we;
  logic [RegAddrWidth-1:0]  dev_addr;
  logic [BusDataWidth-1:0]  dev_wdata;
  logic [BusByteEnable-1:0] dev_sel;
  logic [BusDataWidth-1:0]  gpio_rdata;
  logic [BusDataWidth-1:0]  pwm_rdata;
  logic [BusDataWidth-1:0]  tmr_rdata;

  wb_device_decode u_decode (
    .clk_sys_i, .rst_sys_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_sel_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o, .wb_err_o,
    .gpio_rdata_i(gpio_rdata), .pwm_rdata_i(pwm_rdata), .tmr_rdata_i(tmr_rdata),
    .gpio_req_o  (gpio_req),   .pwm_req_o  (pwm_req),   .tmr_req_o  (tmr_req),
    .dev_we_o    (dev_we),     .dev_addr_o (dev_addr),
    .dev_wdata_o (dev_wdata),  .dev_sel_o  (dev_sel)
  );

  gpio_block u_gpio (
    .clk_sys_i, .rst_sys_ni,
    .req_i(gpio_req), .we_i(dev_we), .reg_addr_i(dev_addr),
    .wdata_i(dev_wdata), .sel_i(dev_sel), .rdata_o(gpio_rdata),
    .gp_i, .gp_o
  );

  pwm_block u_pwm (
    .clk_sys_i, .rst_sys_ni,
    .req_i(pwm_req), .we_i(dev_we), .reg_addr_i(dev_addr),
    .wdata_i(dev_wdata), .sel_i(dev_sel), .rdata_o(pwm_rdata),
    .pwm_o
  );

  mtimer_block u_timer (
    .clk_sys_i, .rst_sys_ni,
    .req_i(tmr_req), .we_i(dev_we), .reg_addr_i(dev_addr),
    .wdata_i(dev_wdata), .sel_i(dev_sel), .rdata_o(tmr_rdata),
    .timer_irq_o
  );

endmodule

`default_nettype wire

//--- sim/tb_periph_subsys.sv
// Peripheral subsystem testbench
`default_nettype none
`timescale 1ns/10ps

module tb_periph_subsys;

  localparam int unsigned CycleLimit = 20000;
  localparam logic [31:0] GpioBase   = 32'h0000_0000;
  localparam logic [31:0] PwmBase    = 32'h0000_0400;
  localparam logic [31:0] TmrBase    = 32'h0000_0800;
  localparam int unsigned CmpLoIdx   = 14;   // Model slots 0 gpo, 1 gpi, 2..13 PWM
  localparam int unsigned CmpHiIdx   = 15;

  logic        clk_sys;
  logic        rst_sys_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [3:0]  wb_sel;
  logic [31:0] wb_wdat;
  logic [31:0] wb_rdat;
  logic        wb_ack;
  logic        wb_err;
  logic [12:0] gp_in;
  logic [23:0] gp_out;
  logic [11:0] pwm_out;
  logic        timer_irq;

  logic [31:0] shadow [16];   // Register model
  logic [31:0] rd_addr_q [$];
  logic [31:0] rd_data_q [$];
  logic        rd_err_q [$];
  int          error_count;
  int          reads_checked;
  int          cycle_count;

  periph_subsys periph_subsys_inst (
    .clk_sys_i   (clk_sys),
    .rst_sys_ni  (rst_sys_n),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_sel_i    (wb_sel),
    .wb_dat_i    (wb_wdat),
    .wb_dat_o    (wb_rdat),
    .wb_ack_o    (wb_ack),
    .wb_err_o    (wb_err),
    .gp_i        (gp_in),
    .gp_o        (gp_out),
    .pwm_o       (pwm_out),
    .timer_irq_o (timer_irq)
  );

  always #50 clk_sys = ~clk_sys;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lane_merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                             input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (new_w & mask) | (old_w & ~mask);
  endfunction

  // Returns {err, data}; mtime reads are not modelled here
  function automatic logic [32:0] expected_read(input logic [31:0] addr,
                                                input logic [31:0] regs [16]);
    logic [7:0]  off;
    logic [31:0] data;
    off  = addr[9:2];
    data = '0;
    if (addr[31:12] != '0 || addr[11:10] == 2'd3) begin
      return {1'b1, 32'h0};
    end
    case (addr[11:10])
      2'd0: begin
        if (off == 8'd0) data = regs[0];
        else if (off == 8'd1) data = regs[1];
      end
      2'd1: begin
        if (off < 8'd12) data = regs[2 + off];
      end
      default: begin
        if (off == 8'd2) data = regs[CmpLoIdx];
        else if (off == 8'd3) data = regs[CmpHiIdx];
      end
    endcase
    return {1'b0, data};
  endfunction

  // Checks queued reads against the model
  always @(posedge clk_sys) begin : compare_reads
    logic [32:0] want;
    logic [31:0] addr;
    logic [31:0] data;
    logic        err;
    while (rd_addr_q.size() > 0) begin
      addr = rd_addr_q.pop_front();
      data = rd_data_q.pop_front();
      err  = rd_err_q.pop_front();
      want = expected_read(addr, shadow);
      reads_checked++;
      if (err !== want[32]) begin
        $display("MISMATCH at %0t: read %h err %b, expected %b", $time, addr, err, want[32]);
        error_count++;
      end else if (!want[32] && data !== want[31:0]) begin
        $display("MISMATCH at %0t: read %h got %h, expected %h", $time, addr, data,
                 want[31:0]);
        error_count++;
      end
    end
  end

  always @(posedge clk_sys) begin : cycle_guard
    cycle_count++;
    if (cycle_count >= CycleLimit) begin
      $display("Run did not finish within %0d cycles", CycleLimit);
      $display("Reads compared: %0d, errors: %0d", reads_checked, error_count + 1);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Wishbone host
  //////////////////////////////////////////////////////////////////////

  task automatic bus_cycle(input logic we, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] sel, output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    rdata  = '0;
    err    = 1'b0;
    @(posedge clk_sys);
    #5;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = addr;
    wb_sel  = sel;
    wb_wdat = data;
    do begin
      @(posedge clk_sys);
      #5;
      waited++;
    end while (!wb_ack && !wb_err && waited < 4);
    if (!wb_ack && !wb_err) begin
      $display("Bus access to %h got no ack or err within 4 cycles", addr);
      error_count++;
    end else begin
      if (wb_ack && wb_err) begin
        $display("Bus access to %h saw ack and err high together", addr);
        error_count++;
      end
      rdata = wb_rdat;
      err   = wb_err;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] sel, input logic exp_err);
    logic [31:0] unused_rdata;
    logic        err;
    bus_cycle(1'b1, addr, data, sel, unused_rdata, err);
    if (err !== exp_err) begin
      $display("MISMATCH at %0t: write %h err %b, expected %b", $time, addr, err, exp_err);
      error_count++;
    end
  endtask

  task automatic wb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    bus_cycle(1'b0, addr, 32'h0, 4'hf, data, err);
  endtask

  task automatic read_and_queue(input logic [31:0] addr);
    logic [31:0] data;
    logic        err;
    wb_read(addr, data, err);
    rd_addr_q.push_back(addr);
    rd_data_q.push_back(data);
    rd_err_q.push_back(err);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    if (gp_out !== '0 || pwm_out !== '0 || timer_irq !== 1'b0 || wb_ack || wb_err) begin
      $display("MISMATCH at %0t: after reset gp_o %h pwm_o %h irq %b ack %b err %b",
               $time, gp_out, pwm_out, timer_irq, wb_ack, wb_err);
      error_count++;
    end
    read_and_queue(TmrBase + 32'h8);
    read_and_queue(TmrBase + 32'hc);
  endtask

  task automatic gpio_output_writes();
    logic [31:0] data;
    logic [3:0]  sel;
    for (int n = 0; n < 40; n++) begin
      data = $urandom;
      sel  = 4'($urandom);
      wb_write(GpioBase, data, sel, 1'b0);
      shadow[0] = lane_merge(shadow[0], data, sel) & 32'h00ff_ffff;  // 24 outputs
      if (gp_out !== shadow[0][23:0]) begin
        $display("MISMATCH at %0t: gp_o %h, expected %h", $time, gp_out, shadow[0][23:0]);
        error_count++;
      end
      read_and_queue(GpioBase);
    end
  endtask

  task automatic gpio_input_sync();
    for (int n = 0; n < 8; n++) begin
      @(posedge clk_sys);
      #5;
      gp_in     = 13'($urandom);
      shadow[1] = 32'(gp_in);
      repeat (3) @(posedge clk_sys);
      read_and_queue(GpioBase + 32'h4);
    end
  endtask

  // High cycles of one channel over a window of samples
  task automatic count_pwm_high(input int ch, input int cycles, output int high);
    high = 0;
    repeat (cycles) begin
      @(posedge clk_sys);
      #5;
      if (pwm_out[ch]) high++;
    end
  endtask

  task automatic pwm_duty_windows();
    logic [7:0]  duty [12];
    logic [7:0]  period [12];
    logic [31:0] word;
    int          high;
    int          want;
    int          zero_ch;
    for (int ch = 0; ch < 12; ch++) begin
      duty[ch]   = 8'($urandom);
      period[ch] = 8'($urandom % 255) + 8'd1;
      word       = {16'($urandom), period[ch], duty[ch]};
      wb_write(PwmBase + 32'(4 * ch), word, 4'hf, 1'b0);
      shadow[2 + ch] = word;
      read_and_queue(PwmBase + 32'(4 * ch));
    end
    repeat (2 * 257) @(posedge clk_sys);
    for (int ch = 0; ch < 12; ch++) begin
      count_pwm_high(ch, int'(period[ch]) + 1, high);
      want = (int'(duty[ch]) < int'(period[ch]) + 1) ? int'(duty[ch]) : int'(period[ch]) + 1;
      if (high != want) begin
        $display("MISMATCH at %0t: PWM channel %0d high %0d of %0d cycles, expected %0d",
                 $time, ch, high, int'(period[ch]) + 1, want);
        error_count++;
      end
    end
    // Period zero keeps the channel low whatever the duty
    zero_ch = $urandom % 12;
    word    = {16'h0, 8'h0, 8'($urandom) | 8'h01};
    wb_write(PwmBase + 32'(4 * zero_ch), word, 4'hf, 1'b0);
    shadow[2 + zero_ch] = word;
    repeat (2 * 257) @(posedge clk_sys);
    count_pwm_high(zero_ch, 257, high);
    if (high != 0) begin
      $display("MISMATCH at %0t: PWM channel %0d with period zero high for %0d cycles",
               $time, zero_ch, high);
      error_count++;
    end
  endtask

  task automatic timer_interrupt();
    logic [31:0] base;
    logic [31:0] lo;
    logic [31:0] hi;
    logic        err;
    int          gap;
    int          waited;
    base = $urandom % 32'hffff_fe0c;   // Below 2^32 - 500
    gap  = 100 + ($urandom % 201);
    wb_write(TmrBase + 32'h4, 32'h0, 4'hf, 1'b0);
    wb_write(TmrBase + 32'h0, base, 4'hf, 1'b0);
    wb_write(TmrBase + 32'h8, base + 32'(gap), 4'hf, 1'b0);
    shadow[CmpLoIdx] = base + 32'(gap);
    wb_write(TmrBase + 32'hc, 32'h0, 4'hf, 1'b0);
    shadow[CmpHiIdx] = 32'h0;
    waited = 0;
    while (!timer_irq && waited < 400) begin
      @(posedge clk_sys);
      #5;
      waited++;
    end
    if (!timer_irq) begin
      $display("Timer interrupt never rose after mtimecmp was set");
      error_count++;
    end else if (waited < 90) begin
      $display("MISMATCH at %0t: timer interrupt rose after %0d cycles, expected 90 or more",
               $time, waited);
      error_count++;
    end
    wb_read(TmrBase + 32'h0, lo, err);
    wb_read(TmrBase + 32'h4, hi, err);
    if ({hi, lo} < {shadow[CmpHiIdx], shadow[CmpLoIdx]}) begin
      $display("MISMATCH at %0t: mtime %h below mtimecmp %h with interrupt high", $time,
               {hi, lo}, {shadow[CmpHiIdx], shadow[CmpLoIdx]});
      error_count++;
    end
    read_and_queue(TmrBase + 32'h8);
    read_and_queue(TmrBase + 32'hc);
    wb_write(TmrBase + 32'hc, 32'hffff_ffff, 4'hf, 1'b0);
    shadow[CmpHiIdx] = 32'hffff_ffff;
    waited = 0;
    while (timer_irq && waited < 2) begin
      @(posedge clk_sys);
      #5;
      waited++;
    end
    if (timer_irq) begin
      $display("Timer interrupt still high 2 cycles after mtimecmp was raised");
      error_count++;
    end
    wb_write(TmrBase + 32'h8, 32'hffff_ffff, 4'hf, 1'b0);
    shadow[CmpLoIdx] = 32'hffff_ffff;
    read_and_queue(TmrBase + 32'h8);
    read_and_queue(TmrBase + 32'hc);
  endtask

  task automatic unmapped_accesses();
    logic [31:0] bad_addr [4];
    bad_addr[0] = 32'h0000_0c00;   // Select value 3
    bad_addr[1] = 32'h0000_1000;   // GPIO out plus bit 12
    bad_addr[2] = 32'h8000_0400;   // PWM channel 0 plus bit 31
    bad_addr[3] = 32'h0001_0808;   // Timer compare plus bit 16
    foreach (bad_addr[k]) begin
      wb_write(bad_addr[k], $urandom, 4'hf, 1'b1);
      read_and_queue(bad_addr[k]);
    end
    read_and_queue(GpioBase);
    read_and_queue(PwmBase);
    read_and_queue(TmrBase + 32'h8);
    // Unused offsets inside mapped devices
    wb_write(GpioBase + 32'h14, $urandom, 4'hf, 1'b0);
    read_and_queue(GpioBase + 32'h14);
    wb_write(PwmBase + 32'h50, $urandom, 4'hf, 1'b0);
    read_and_queue(PwmBase + 32'h50);
    wb_write(TmrBase + 32'h1c, $urandom, 4'hf, 1'b0);
    read_and_queue(TmrBase + 32'h1c);
    read_and_queue(GpioBase);
  endtask

  initial begin : main_sequence
    clk_sys   = 1'b0;
    rst_sys_n = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_sel    = '0;
    wb_wdat   = '0;
    gp_in     = '0;
    error_count   = 0;
    reads_checked = 0;
    cycle_count   = 0;
    void'($urandom(32'hdbf8));
    for (int r = 0; r < 16; r++) begin
      shadow[r] = '0;
    end
    shadow[CmpLoIdx] = '1;   // mtimecmp resets to all ones
    shadow[CmpHiIdx] = '1;
    repeat (2) @(posedge clk_sys);
    #5;
    rst_sys_n = 1'b1;

    check_reset_state();
    gpio_output_writes();
    gpio_input_sync();
    pwm_duty_windows();
    timer_interrupt();
    unmapped_accesses();

    repeat (2) @(posedge clk_sys);
    #5;
    if (rd_addr_q.size() != 0) begin
      $display("Some reads were never compared");
      error_count++;
    end
    $display("Reads compared: %0d, errors: %0d", reads_checked, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- periph_subsys.f
rtl/periph_bus_pkg.sv
rtl/periph_reg_pkg.sv
rtl/wb_device_decode.sv
rtl/gpio_block.sv
rtl/pwm_block.sv
rtl/mtimer_block.sv
rtl/periph_subsys.sv
sim/tb_periph_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the peripheral subsystem testbench with Verilator and run it.
# Exit status is zero only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f periph_subsys.f \
  --top-module tb_periph_subsys \
  --Mdir obj_dir -o tb_periph_subsys &&
  sim_out="$(./obj_dir/tb_periph_subsys)"

echo "$sim_out"

echo "$sim_out" | grep -qx "STATUS: PASS" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
